// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module fsx
	verilator --lint-only --timing -f filelist.f --top-module fsx_tb

sim:
	verilator --binary --timing -j 0 -f filelist.f --top-module fsx_tb -Mdir obj_dir
	./obj_dir/Vfsx_tb | tee sim.log
	grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
+incdir+verification
rtl/fsx_pkg.sv
rtl/fsx_timing.sv
rtl/fsx_bg_renderer.sv
rtl/fsx_sprite_renderer.sv
rtl/fsx_pixel_mixer.sv
rtl/fsx.sv
verification/fsx_tb.sv

// File: rtl/fsx.sv
`timescale 1ns/1ps

module fsx (
    input  logic                vga_clk,
    input  logic                i_rst_n,
    output logic [13:0]         o_vram8_addr,              // tile map
    input  logic [7:0]          i_vram8_q,
    output logic [13:0]         o_vram32_addr,             // background patterns
    input  fsx_pkg::vram_word_u i_vram32_q,
    output logic [13:0]         o_vram322_addr,            // sprite attributes and patterns
    input  fsx_pkg::vram_word_u i_vram322_q,
    output logic [2:0]          o_vga_r,
    output logic [2:0]          o_vga_g,
    output logic [1:0]          o_vga_b,
    output logic                o_vga_hs,
    output logic                o_vga_vs,
    output logic                o_vga_de,
    output logic                o_frame_drawn              // one pulse per frame
);
    import fsx_pkg::*;

    logic       de;
    logic       hs;
    logic       vs;
    logic       hblank;
    logic [8:0] h;
    logic [8:0] v;
    rgb332_t    bg_rgb;
    logic       bg_opaque;
    rgb332_t    spr_rgb;
    logic       spr_hit;
    logic       spr_behind;

    fsx_timing u_timing (
        .vga_clk       (vga_clk),
        .i_rst_n       (i_rst_n),
        .o_de          (de),
        .o_hs          (hs),
        .o_vs          (vs),
        .o_hblank      (hblank),
        .o_line_start  (),                                 // no consumer on this chip
        .o_frame_drawn (o_frame_drawn),
        .o_h           (h),
        .o_v           (v)
    );

    fsx_bg_renderer u_bg (
        .vga_clk       (vga_clk),
        .i_rst_n       (i_rst_n),
        .i_de          (de),
        .i_h           (h),
        .i_v           (v),
        .o_vram8_addr  (o_vram8_addr),
        .i_vram8_q     (i_vram8_q),
        .o_vram32_addr (o_vram32_addr),
        .i_vram32_q    (i_vram32_q),
        .o_bg_rgb      (bg_rgb),
        .o_bg_opaque   (bg_opaque)
    );

    fsx_sprite_renderer u_spr (
        .vga_clk       (vga_clk),
        .i_rst_n       (i_rst_n),
        .i_de          (de),
        .i_hblank      (hblank),
        .i_h           (h),
        .i_v           (v),
        .o_vram_addr   (o_vram322_addr),                   // copy of vram32
        .i_vram_q      (i_vram322_q),
        .o_spr_rgb     (spr_rgb),
        .o_spr_hit     (spr_hit),
        .o_spr_behind  (spr_behind)
    );

    fsx_pixel_mixer u_mix (
        .vga_clk       (vga_clk),
        .i_rst_n       (i_rst_n),
        .i_de          (de),
        .i_hs          (hs),
        .i_vs          (vs),
        .i_bg_rgb      (bg_rgb),
        .i_bg_opaque   (bg_opaque),
        .i_spr_rgb     (spr_rgb),
        .i_spr_hit     (spr_hit),
        .i_spr_behind  (spr_behind),
        .o_vga_r       (o_vga_r),
        .o_vga_g       (o_vga_g),
        .o_vga_b       (o_vga_b),
        .o_vga_hs      (o_vga_hs),
        .o_vga_vs      (o_vga_vs),
        .o_vga_de      (o_vga_de)
    );

endmodule

// File: rtl/fsx_bg_renderer.sv
`timescale 1ns/1ps

module fsx_bg_renderer (
    input  logic                vga_clk,
    input  logic                i_rst_n,
    input  logic                i_de,
    input  logic [8:0]          i_h,
    input  logic [8:0]          i_v,
    output logic [13:0]         o_vram8_addr,
    input  logic [7:0]          i_vram8_q,
    output logic [13:0]         o_vram32_addr,
    input  fsx_pkg::vram_word_u i_vram32_q,
    output fsx_pkg::rgb332_t    o_bg_rgb,
    output logic                o_bg_opaque
);
    import fsx_pkg::*;

    logic [2:0] s1_fx;                                     // fine x while tile is fetched
    logic [2:0] s1_row;                                    // v mod 8 while tile is fetched
    logic [2:0] s2_fx;                                     // fine x while pattern is fetched
    logic       s2_odd;                                    // row parity picks word half
    logic       s2_de;
    logic [1:0] pix;

    // stage 0, tile map read from the coordinates
    assign o_vram8_addr  = 14'(i_v[8:3]) * 14'(MAP_COLS) + 14'(i_h[8:3]);

    // stage 1, pattern word is tile*4 plus row pair
    assign o_vram32_addr = {4'd0, i_vram8_q, s1_row[2:1]};

    always_ff @(posedge vga_clk)
    begin
        s1_fx  <= i_h[2:0];
        s1_row <= i_v[2:0];
        s2_fx  <= s1_fx;
        s2_odd <= s1_row[0];
    end

    // de trails the coordinates by one cycle, so it joins at stage 1
    always_ff @(posedge vga_clk)
    begin
        if (!i_rst_n)
        begin
            s2_de <= 1'b0;
        end
        else
        begin
            s2_de <= i_de;
        end
    end

    // stage 2, pattern word is on the bus
    always_comb
    begin
        pix         = pat_pixel(i_vram32_q, s2_odd, s2_fx);
        o_bg_rgb    = s2_de ? BG_PALETTE[pix] : '0;        // black in blanking
        o_bg_opaque = s2_de && (pix != 2'd0);
    end

endmodule

// File: rtl/fsx_pixel_mixer.sv
`timescale 1ns/1ps

module fsx_pixel_mixer (
    input  logic             vga_clk,
    input  logic             i_rst_n,
    input  logic             i_de,
    input  logic             i_hs,
    input  logic             i_vs,
    input  fsx_pkg::rgb332_t i_bg_rgb,
    input  logic             i_bg_opaque,
    input  fsx_pkg::rgb332_t i_spr_rgb,
    input  logic             i_spr_hit,
    input  logic             i_spr_behind,
    output logic [2:0]       o_vga_r,
    output logic [2:0]       o_vga_g,
    output logic [1:0]       o_vga_b,
    output logic             o_vga_hs,
    output logic             o_vga_vs,
    output logic             o_vga_de
);
    import fsx_pkg::*;

    logic [PIPE_LAT-2:0] de_pipe;                          // [0] lines up with renderers
    logic [PIPE_LAT-2:0] hs_pipe;
    logic [PIPE_LAT-2:0] vs_pipe;
    logic                spr_wins;
    rgb332_t             mix_rgb;
    rgb332_t             pix_q;                            // colour on the pins

    // behind sprite loses only to an opaque background pixel
    assign spr_wins = i_spr_hit && !(i_spr_behind && i_bg_opaque);
    assign mix_rgb  = spr_wins ? i_spr_rgb : i_bg_rgb;

    always_ff @(posedge vga_clk)
    begin
        if (!i_rst_n)
        begin
            de_pipe <= '0;
            hs_pipe <= '1;                                 // syncs idle high
            vs_pipe <= '1;
            pix_q   <= '0;
        end
        else
        begin
            de_pipe <= {de_pipe[PIPE_LAT-3:0], i_de};
            hs_pipe <= {hs_pipe[PIPE_LAT-3:0], i_hs};
            vs_pipe <= {vs_pipe[PIPE_LAT-3:0], i_vs};
            pix_q   <= de_pipe[0] ? mix_rgb : '0;          // zero outside enable
        end
    end

    assign o_vga_r  = pix_q.r;
    assign o_vga_g  = pix_q.g;
    assign o_vga_b  = pix_q.b;
    assign o_vga_de = de_pipe[PIPE_LAT-2];
    assign o_vga_hs = hs_pipe[PIPE_LAT-2];
    assign o_vga_vs = vs_pipe[PIPE_LAT-2];

endmodule

// File: rtl/fsx_pkg.sv
package fsx_pkg;

    localparam int H_RES   = 480;                          // visible pixels per line
    localparam int V_RES   = 272;                          // visible lines per frame
    localparam int H_FP    = 2;
    localparam int H_SYNC  = 41;
    localparam int H_BP    = 2;
    localparam int V_FP    = 2;
    localparam int V_SYNC  = 10;
    localparam int V_BP    = 2;
    localparam int H_TOTAL = H_FP + H_SYNC + H_BP + H_RES;  // 525
    localparam int V_TOTAL = V_FP + V_SYNC + V_BP + V_RES;  // 286
    localparam int HS_BEG  = H_FP;                         // first sync pixel
    localparam int HS_END  = H_FP + H_SYNC;                // first back porch pixel
    localparam int HA_BEG  = HS_END + H_BP;                // first active pixel
    localparam int VS_BEG  = V_FP;
    localparam int VS_END  = V_FP + V_SYNC;
    localparam int VA_BEG  = VS_END + V_BP;                // first active line

    localparam int          PIPE_LAT      = 3;             // counters to pins
    localparam int          MAP_COLS      = 64;            // tile map stride in vram8
    localparam logic [13:0] SPR_ATTR_BASE = 14'h3f00;      // four attribute words
    localparam logic [13:0] SPR_PAT_BASE  = 14'h3000;      // sprite patterns in vram322
    localparam int          NUM_SPRITES   = 4;
    localparam int          SPR_IDX_W     = $clog2(NUM_SPRITES);
    localparam int          LD_CNT_W      = SPR_IDX_W + 1; // hblank load sequencer

    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } rgb332_t;

    // two rows of eight 2-bit pixels, leftmost pixel in the high bits
    typedef struct packed {
        logic [7:0][1:0] even_row;
        logic [7:0][1:0] odd_row;
    } pat_view_t;

    typedef struct packed {
        logic [8:0] x;                                     // left edge in active pixels
        logic [8:0] y;                                     // top edge in active lines
        rgb332_t    colour;
        logic [3:0] tile;                                  // pattern index in sprite region
        logic       behind;                                // only over bg pixel 0
        logic       enable;
    } attr_view_t;

    typedef union packed {
        pat_view_t  pat;
        attr_view_t attr;
    } vram_word_u;

    localparam rgb332_t BG_PALETTE [4] = '{
        '{r: 3'd0, g: 3'd0, b: 2'd1},                      // 0 is dark blue, counts as clear
        '{r: 3'd1, g: 3'd4, b: 2'd1},
        '{r: 3'd6, g: 3'd3, b: 2'd0},
        '{r: 3'd7, g: 3'd7, b: 2'd3}
    };

    // pick one 2-bit pixel out of a pattern word
    function automatic logic [1:0] pat_pixel(input vram_word_u w, input logic odd,
                                             input logic [2:0] fx);
        logic [7:0][1:0] row;
        row = odd ? w.pat.odd_row : w.pat.even_row;
        return row[3'd7 - fx];                             // fx 0 is the high pair
    endfunction

endpackage

// File: rtl/fsx_sprite_renderer.sv
`timescale 1ns/1ps

module fsx_sprite_renderer (
    input  logic                vga_clk,
    input  logic                i_rst_n,
    input  logic                i_de,
    input  logic                i_hblank,
    input  logic [8:0]          i_h,
    input  logic [8:0]          i_v,
    output logic [13:0]         o_vram_addr,
    input  fsx_pkg::vram_word_u i_vram_q,
    output fsx_pkg::rgb332_t    o_spr_rgb,
    output logic                o_spr_hit,
    output logic                o_spr_behind
);
    import fsx_pkg::*;

    vram_word_u             spr_attr [NUM_SPRITES];        // held for the whole line
    logic [NUM_SPRITES-1:0] spr_en;
    logic [LD_CNT_W-1:0]    ld_cnt;                        // cycles into hblank
    logic                   ld_rd;                         // attribute read this cycle
    logic [SPR_IDX_W-1:0]   ld_idx;
    logic                   ld_req_q;                      // attribute word on the bus
    logic [SPR_IDX_W-1:0]   ld_idx_q;
    logic                   hit_any;
    logic [SPR_IDX_W-1:0]   hit_idx;
    logic [2:0]             hit_fx;
    logic [2:0]             hit_dy;
    logic                   s1_hit;
    logic [SPR_IDX_W-1:0]   s1_idx;
    logic [2:0]             s1_fx;
    logic [2:0]             s1_dy;
    logic [13:0]            pat_addr;
    logic                   s2_hit;
    logic [2:0]             s2_fx;
    logic                   s2_odd;
    rgb332_t                s2_rgb;
    logic                   s2_behind;
    logic [1:0]             pix;

    // skip the first hblank cycle, the last pixel's pattern fetch uses the port
    assign ld_rd  = i_hblank && (ld_cnt != '0) && (ld_cnt <= LD_CNT_W'(NUM_SPRITES));
    assign ld_idx = SPR_IDX_W'(ld_cnt - LD_CNT_W'(1));

    // stage 0, lowest enabled index inside its 8x8 box wins
    always_comb
    begin
        logic [9:0] dx;
        logic [9:0] dy;
        hit_any = 1'b0;
        hit_idx = '0;
        hit_fx  = '0;
        hit_dy  = '0;
        for (int i = NUM_SPRITES - 1; i >= 0; i--)         // low index overwrites
        begin
            dx = {1'b0, i_h} - {1'b0, spr_attr[i].attr.x}; // negative sets bit 9
            dy = {1'b0, i_v} - {1'b0, spr_attr[i].attr.y};
            if (spr_en[i] && (dx[9:3] == 7'd0) && (dy[9:3] == 7'd0))
            begin
                hit_any = 1'b1;
                hit_idx = SPR_IDX_W'(i);
                hit_fx  = dx[2:0];
                hit_dy  = dy[2:0];
            end
        end
    end

    // stage 1, pattern read for the winner, shares the port with attribute loads
    assign pat_addr    = SPR_PAT_BASE + {8'd0, spr_attr[s1_idx].attr.tile, s1_dy[2:1]};
    assign o_vram_addr = ld_rd ? SPR_ATTR_BASE + 14'(ld_idx) : pat_addr;

    always_ff @(posedge vga_clk)
    begin
        ld_idx_q <= ld_idx;
        if (ld_req_q)
        begin
            spr_attr[ld_idx_q] <= i_vram_q;                // attribute view of the word
        end
        s1_idx    <= hit_idx;
        s1_fx     <= hit_fx;
        s1_dy     <= hit_dy;
        s2_fx     <= s1_fx;
        s2_odd    <= s1_dy[0];
        s2_rgb    <= spr_attr[s1_idx].attr.colour;
        s2_behind <= spr_attr[s1_idx].attr.behind;
    end

    always_ff @(posedge vga_clk)
    begin
        if (!i_rst_n)
        begin
            ld_cnt   <= '0;
            ld_req_q <= 1'b0;
            spr_en   <= '0;
            s1_hit   <= 1'b0;
            s2_hit   <= 1'b0;
        end
        else
        begin
            if (!i_hblank)
            begin
                ld_cnt <= '0;
            end
            else if (ld_cnt != LD_CNT_W'(NUM_SPRITES + 1))
            begin
                ld_cnt <= ld_cnt + LD_CNT_W'(1);           // stops after the last read
            end
            ld_req_q <= ld_rd;
            if (ld_req_q)
            begin
                spr_en[ld_idx_q] <= i_vram_q.attr.enable;
            end
            s1_hit <= hit_any;
            s2_hit <= s1_hit && i_de;                      // de lags coordinates by one
        end
    end

    // stage 2, pattern view of the word, pixel 0 is see-through
    always_comb
    begin
        pix          = pat_pixel(i_vram_q, s2_odd, s2_fx);
        o_spr_hit    = s2_hit && (pix != 2'd0);
        o_spr_rgb    = o_spr_hit ? s2_rgb : '0;
        o_spr_behind = s2_behind;
    end

endmodule

// File: rtl/fsx_timing.sv
`timescale 1ns/1ps

module fsx_timing (
    input  logic       vga_clk,
    input  logic       i_rst_n,
    output logic       o_de,
    output logic       o_hs,
    output logic       o_vs,
    output logic       o_hblank,
    output logic       o_line_start,
    output logic       o_frame_drawn,
    output logic [8:0] o_h,
    output logic [8:0] o_v
);
    import fsx_pkg::*;

    logic [9:0] h_cnt;                                     // pixel position in line
    logic [8:0] v_cnt;                                     // line position in frame
    logic [9:0] h_nxt;
    logic [8:0] v_nxt;
    logic       act_nxt;                                   // next position is visible

    always_comb
    begin
        h_nxt = h_cnt + 10'd1;
        v_nxt = v_cnt;
        if (h_cnt == 10'(H_TOTAL - 1))                     // line wrap
        begin
            h_nxt = '0;
            v_nxt = (v_cnt == 9'(V_TOTAL - 1)) ? '0 : v_cnt + 9'd1;
        end
        act_nxt = (h_nxt >= 10'(HA_BEG)) && (v_nxt >= 9'(VA_BEG));
    end

    // coordinates, hblank and line start are built from the next count, so they
    // sit level with the counters and give the fetch pipes one cycle of lead
    // de, syncs and the frame pulse trail the counters by one cycle
    always_ff @(posedge vga_clk)
    begin
        if (!i_rst_n)
        begin
            h_cnt         <= '0;
            v_cnt         <= '0;
            o_h           <= '0;
            o_v           <= '0;
            o_hblank      <= 1'b1;                         // counters restart in front porch
            o_line_start  <= 1'b1;
            o_de          <= 1'b0;
            o_hs          <= 1'b1;                         // syncs idle high
            o_vs          <= 1'b1;
            o_frame_drawn <= 1'b0;
        end
        else
        begin
            h_cnt         <= h_nxt;
            v_cnt         <= v_nxt;
            o_h           <= act_nxt ? 9'(h_nxt - 10'(HA_BEG)) : '0;
            o_v           <= act_nxt ? v_nxt - 9'(VA_BEG) : '0;
            o_hblank      <= h_nxt < 10'(HA_BEG);
            o_line_start  <= h_nxt == '0;
            o_de          <= (h_cnt >= 10'(HA_BEG)) && (v_cnt >= 9'(VA_BEG));
            o_hs          <= !((h_cnt >= 10'(HS_BEG)) && (h_cnt < 10'(HS_END)));
            o_vs          <= !((v_cnt >= 9'(VS_BEG)) && (v_cnt < 9'(VS_END)));
            o_frame_drawn <= (h_cnt == 10'(H_TOTAL - 1)) && (v_cnt == 9'(V_TOTAL - 1));
        end
    end

endmodule

// File: verification/fsx_model.svh
`ifndef FSX_MODEL_SVH
`define FSX_MODEL_SVH

int unsigned rgb_errs    = 0;
int unsigned bit_errs    = 0;
int unsigned count_errs  = 0;
int          ph          = 0;                              // counter position now on the pins
int          pv          = 0;
int          de_in_line  = 0;
int          hs_low      = 0;
int          de_lines    = 0;                              // lines with any enabled pixel
int          frames_seen = 0;
int          pulses      = 0;

// even row in the upper half, column 0 in the top pair
function automatic logic [1:0] pixel_at(input logic [31:0] w, input int row, input int col);
    logic [15:0] half;
    half = (row % 2 == 0) ? w[31:16] : w[15:0];
    return 2'(half >> (14 - 2 * col));
endfunction

function automatic rgb332_t expected_rgb(input int h, input int v);
    int         ax;
    int         ay;
    int         dx;
    int         dy;
    logic [7:0] tile;
    logic [1:0] bpix;
    logic [1:0] spix;
    logic       found;
    vram_word_u s;
    rgb332_t    res;
    ax = h - (H_FP + H_SYNC + H_BP);
    ay = v - (V_FP + V_SYNC + V_BP);
    if (ax < 0 || ay < 0)
        return '0;                                         // blanking is black
    tile  = vram8[14'((ay / 8) * MAP_COLS + ax / 8)];
    bpix  = pixel_at(vram32[14'(int'(tile) * 4 + (ay % 8) / 2)], ay % 8, ax % 8);
    res   = BG_PALETTE[bpix];                              // pixel 0 still has a colour
    found = 1'b0;
    for (int i = 0; i < NUM_SPRITES; i++)
    begin
        s  = spr[2'(i)];
        dx = ax - int'(s.attr.x);
        dy = ay - int'(s.attr.y);
        if (!found && s.attr.enable && dx >= 0 && dx < 8 && dy >= 0 && dy < 8)
        begin
            found = 1'b1;                                  // first box wins, no fallback
            spix  = pixel_at(vram322[SPR_PAT_BASE + 14'(int'(s.attr.tile) * 4 + dy / 2)],
                             dy, dx);
            if (spix != 2'd0 && !(s.attr.behind && bpix != 2'd0))
                res = s.attr.colour;
        end
    end
    return res;
endfunction

task automatic check_rgb(input string name, input rgb332_t got, input rgb332_t want);
    if (got !== want)
    begin
        rgb_errs++;
        $display("ERR %s got %h exp %h at h %0d v %0d", name, got, want, ph, pv);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want)
    begin
        bit_errs++;
        $display("ERR %s got %h exp %h at h %0d v %0d", name, got, want, ph, pv);
    end
endtask

task automatic check_count(input string name, input int got, input int want);
    if (got != want)
    begin
        count_errs++;
        $display("ERR %s got %h exp %h at h %0d v %0d", name, got, want, ph, pv);
    end
endtask

// one sample per cycle, k counts edges since reset release
task automatic check_cycle(input int unsigned k);
    logic want_hs;
    logic want_de;
    want_hs = !(ph >= H_FP && ph < H_FP + H_SYNC);
    want_de = (ph >= H_FP + H_SYNC + H_BP) && (pv >= V_FP + V_SYNC + V_BP);
    check_bit("o_frame_drawn", frame_drawn, k != 0 && k % (H_TOTAL * V_TOTAL) == 0);
    if (frame_drawn)
        pulses++;
    if (k < PIPE_LAT)
    begin                                                  // pipe still shows reset levels
        check_bit("o_vga_hs", vga_hs, 1'b1);
        check_bit("o_vga_vs", vga_vs, 1'b1);
        check_bit("o_vga_de", vga_de, 1'b0);
        check_rgb("o_vga_rgb", pin_rgb, '0);
    end
    else
    begin
        check_bit("o_vga_hs", vga_hs, want_hs);
        check_bit("o_vga_vs", vga_vs, !(pv >= V_FP && pv < V_FP + V_SYNC));
        check_bit("o_vga_de", vga_de, want_de);
        check_rgb("o_vga_rgb", pin_rgb, expected_rgb(ph, pv));
        if (!vga_de)
            check_rgb("o_vga_rgb while o_vga_de low", pin_rgb, '0);
        if (vga_de)
            de_in_line++;
        if (!vga_hs)
            hs_low++;
        if (ph == H_TOTAL - 1)
        begin                                              // line just left the pins
            check_count("o_vga_de count per line", de_in_line,
                        (pv >= V_FP + V_SYNC + V_BP) ? H_RES : 0);
            check_count("o_vga_hs low count per line", hs_low, H_SYNC);
            if (de_in_line != 0)
                de_lines++;
            de_in_line = 0;
            hs_low     = 0;
            if (pv == V_TOTAL - 1)
            begin
                check_count("o_vga_de lines per frame", de_lines, V_RES);
                de_lines = 0;
                frames_seen++;
            end
        end
        ph = (ph == H_TOTAL - 1) ? 0 : ph + 1;
        if (ph == 0)
            pv = (pv == V_TOTAL - 1) ? 0 : pv + 1;
    end
endtask

`endif

// File: verification/fsx_tb.sv
`timescale 1ns/1ps

module fsx_tb;
    import fsx_pkg::*;

    logic        vga_clk   = 1'b0;
    logic        i_rst_n   = 1'b0;                         // low for the first three edges
    logic [13:0] vram8_addr;
    logic [7:0]  vram8_q   = '0;
    logic [13:0] vram32_addr;
    vram_word_u  vram32_q  = '0;
    logic [13:0] vram322_addr;
    vram_word_u  vram322_q = '0;
    logic [2:0]  vga_r;
    logic [2:0]  vga_g;
    logic [1:0]  vga_b;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_de;
    logic        frame_drawn;
    rgb332_t     pin_rgb;
    logic [7:0]  vram8   [16384];                          // tile map
    logic [31:0] vram32  [16384];                          // background patterns
    logic [31:0] vram322 [16384];                          // sprite side copy
    vram_word_u  spr     [NUM_SPRITES];                    // attributes as written
    logic [31:0] lfsr    = 32'hc25d;
    int unsigned cyc     = 0;                              // edges since reset release
    logic        ok;

    `include "fsx_model.svh"

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 32'h80200003;
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
            val = {val[30:0], next_bit()};
        return val;
    endfunction

    task automatic place_sprite(input int idx, input int x, input int y, input logic behind,
                                input logic en);
        vram_word_u w;
        w.attr.x      = 9'(x);
        w.attr.y      = 9'(y);
        w.attr.colour = 8'(rand_bits(8));
        w.attr.tile   = 4'(rand_bits(4));
        w.attr.behind = behind;
        w.attr.enable = en;
        spr[2'(idx)]  = w;
        vram32[SPR_ATTR_BASE + 14'(idx)]  = w;             // keep both ports identical
        vram322[SPR_ATTR_BASE + 14'(idx)] = w;
    endtask

    task automatic fill_memories();
        for (int i = 0; i < 16384; i++)
        begin
            vram8[14'(i)]   = 8'(rand_bits(8));
            vram32[14'(i)]  = rand_bits(32);
            vram322[14'(i)] = vram32[14'(i)];
        end
        place_sprite(0, 0, 0, 1'b0, 1'b1);                 // top left corner
        place_sprite(1, 4, 3, 1'b1, 1'b1);                 // behind, under sprite 0
        place_sprite(2, 476, 268, 1'b0, 1'b1);             // clipped right and bottom
        place_sprite(3, 6, 6, 1'b0, 1'b0);                 // disabled over 0 and 1
    endtask

    task automatic wait_pulse(output logic seen);
        seen = 1'b0;
        for (int n = 0; n < H_TOTAL * V_TOTAL + 16 && !seen; n++)
        begin
            @(negedge vga_clk);
            seen = frame_drawn;
        end
    endtask

    assign pin_rgb = {vga_r, vga_g, vga_b};

    fsx dut (
        .vga_clk        (vga_clk),
        .i_rst_n        (i_rst_n),
        .o_vram8_addr   (vram8_addr),
        .i_vram8_q      (vram8_q),
        .o_vram32_addr  (vram32_addr),
        .i_vram32_q     (vram32_q),
        .o_vram322_addr (vram322_addr),
        .i_vram322_q    (vram322_q),
        .o_vga_r        (vga_r),
        .o_vga_g        (vga_g),
        .o_vga_b        (vga_b),
        .o_vga_hs       (vga_hs),
        .o_vga_vs       (vga_vs),
        .o_vga_de       (vga_de),
        .o_frame_drawn  (frame_drawn)
    );

    always #4 vga_clk = ~vga_clk;                          // 8 ns period

    always @(posedge vga_clk)
    begin                                                  // one cycle read latency
        vram8_q   <= vram8[vram8_addr];
        vram32_q  <= vram32[vram32_addr];
        vram322_q <= vram322[vram322_addr];
    end

    always @(negedge vga_clk)
    begin
        if (i_rst_n)
        begin
            check_cycle(cyc);                              // outputs settled since posedge
            cyc++;
        end
    end

    initial
    begin
        fill_memories();
        repeat (3) @(posedge vga_clk);
        i_rst_n <= 1'b1;
        wait_pulse(ok);
        if (ok)
            wait_pulse(ok);
        if (ok)
        begin
            repeat (2 * PIPE_LAT) @(negedge vga_clk);      // last pixels drain to the pins
            check_count("frame ends seen", frames_seen, 2);
            check_count("o_frame_drawn pulses", pulses, 2);
        end
        else
            $display("timeout, o_frame_drawn did not pulse within one frame time");
        $display("errors: colour %0d, bit %0d, count %0d", rgb_errs, bit_errs, count_errs);
        if (ok && rgb_errs + bit_errs + count_errs == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
